// File: sram_queue_pkg.sv
/* shared widths, queue-id / payload / mask types and the memory word layout
   for the four-queue sram packet buffer */
package sram_queue_pkg;

    localparam int NUM_QUEUES     = 4;
    localparam int QUEUE_ID_WIDTH = 2;
    localparam int PAYLOAD_WIDTH  = 8*32 + 9; // 32 data bytes plus 9 control bits

    // one chip lane carries three 36-bit memory words, so the joined
    // word is wide enough for payload, queue id and the valid flag
    localparam int CHIP_WORD_WIDTH = 36;
    localparam int LANE_WIDTH      = 3*CHIP_WORD_WIDTH;
    localparam int NUM_LANES       = 3;
    localparam int MEM_WORD_WIDTH  = NUM_LANES*LANE_WIDTH;

    localparam int FULL_MARGIN = 5; // full asserts this many words below region size

    //////////////////////////////
    // memory word layout, lsb first
    //////////////////////////////
    localparam int QID_LSB    = PAYLOAD_WIDTH;
    localparam int VALID_BIT  = PAYLOAD_WIDTH + QUEUE_ID_WIDTH;
    localparam int PAD_WIDTH  = MEM_WORD_WIDTH - VALID_BIT - 1;

    typedef logic [QUEUE_ID_WIDTH-1:0] queue_id_t;
    typedef logic [PAYLOAD_WIDTH-1:0]  payload_t;
    typedef logic [NUM_QUEUES-1:0]     queue_mask_t;

endpackage

// File: queue_write_ctrl.sv
/* write side: per-queue write offsets, burst alternation and the
   registered memory write word, address and strobe */
`timescale 1ns/1ps

module queue_write_ctrl
#(
    parameter int ADDR_WIDTH = 19
)
(
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   write_data_valid,
    input  sram_queue_pkg::queue_id_t              write_queue_id,
    input  sram_queue_pkg::payload_t               write_data,
    input  sram_queue_pkg::queue_mask_t            write_full,
    output logic                                   write_taken,
    output sram_queue_pkg::queue_id_t              write_taken_id,
    output logic [sram_queue_pkg::MEM_WORD_WIDTH-1:0] dout,
    output logic [ADDR_WIDTH-1:0]                  dout_addr,
    output logic                                   dout_burst_ready
);

    localparam int OFFSET_WIDTH = ADDR_WIDTH - sram_queue_pkg::QUEUE_ID_WIDTH;

    logic [OFFSET_WIDTH-1:0] write_offset [sram_queue_pkg::NUM_QUEUES];
    logic                    burst_halfway; // second cycle of a burst, no take

    // take decision, seen by occupancy in the same cycle
    assign write_taken    = write_data_valid && !burst_halfway
                            && !write_full[write_queue_id];
    assign write_taken_id = write_queue_id;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            burst_halfway    <= 1'b0;
            dout_burst_ready <= 1'b0;
            for (int q = 0; q < sram_queue_pkg::NUM_QUEUES; q++)
                write_offset[q] <= '0; // region base
        end
        else
        begin
            burst_halfway    <= write_taken;
            dout_burst_ready <= write_taken;
            if (write_taken)
                write_offset[write_queue_id] <= write_offset[write_queue_id] + 1'b1; // wraps in region
        end
    end

    // memory word and address, captured on the take
    always_ff @(posedge clk)
    begin
        if (write_taken)
        begin
            dout      <= {{sram_queue_pkg::PAD_WIDTH{1'b0}}, 1'b1, write_queue_id, write_data};
            dout_addr <= {write_queue_id, write_offset[write_queue_id]};
        end
    end

endmodule

// File: queue_read_ctrl.sv
/* read side: per-queue read offsets, burst alternation and the
   registered read request to memory */
`timescale 1ns/1ps

module queue_read_ctrl
#(
    parameter int ADDR_WIDTH = 19
)
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        read_data_ready,
    input  sram_queue_pkg::queue_id_t   read_queue_id,
    input  sram_queue_pkg::queue_mask_t read_empty,
    output logic                        read_taken,
    output sram_queue_pkg::queue_id_t   read_taken_id,
    output logic [ADDR_WIDTH-1:0]       din_addr,
    output logic                        din_ready
);

    localparam int OFFSET_WIDTH = ADDR_WIDTH - sram_queue_pkg::QUEUE_ID_WIDTH;

    logic [OFFSET_WIDTH-1:0] read_offset [sram_queue_pkg::NUM_QUEUES];
    logic                    burst_halfway;

    // an empty queue blocks only its own reads
    assign read_taken    = read_data_ready && !burst_halfway && !read_empty[read_queue_id];
    assign read_taken_id = read_queue_id;

    //////////////////////////////
    // pointers and burst state
    //////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            burst_halfway <= 1'b0;
            din_ready     <= 1'b0;
            for (int q = 0; q < sram_queue_pkg::NUM_QUEUES; q++)
                read_offset[q] <= '0;
        end
        else
        begin
            burst_halfway <= read_taken; // idle again after one cycle
            din_ready     <= read_taken;
            if (read_taken)
                read_offset[read_queue_id] <= read_offset[read_queue_id] + 1'b1;
        end
    end

    // request address, valid while din_ready is high
    always_ff @(posedge clk)
    begin
        if (read_taken)
            din_addr <= {read_queue_id, read_offset[read_queue_id]};
    end

endmodule

// File: queue_occupancy.sv
/* per-queue word counters fed by both take strobes,
   combinational empty and registered full flags */
`timescale 1ns/1ps

module queue_occupancy
#(
    parameter int ADDR_WIDTH = 19
)
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        write_taken,
    input  sram_queue_pkg::queue_id_t   write_taken_id,
    input  logic                        read_taken,
    input  sram_queue_pkg::queue_id_t   read_taken_id,
    output sram_queue_pkg::queue_mask_t read_empty,
    output sram_queue_pkg::queue_mask_t write_full
);

    localparam int OFFSET_WIDTH = ADDR_WIDTH - sram_queue_pkg::QUEUE_ID_WIDTH;
    localparam int COUNT_WIDTH  = OFFSET_WIDTH + 1; // holds a completely full region
    localparam int REGION_SIZE  = 1 << OFFSET_WIDTH;
    localparam logic [COUNT_WIDTH-1:0] FULL_LEVEL =
        COUNT_WIDTH'(REGION_SIZE - sram_queue_pkg::FULL_MARGIN);

    logic [COUNT_WIDTH-1:0] word_count [sram_queue_pkg::NUM_QUEUES];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int q = 0; q < sram_queue_pkg::NUM_QUEUES; q++)
            begin
                word_count[q] <= '0;
                write_full[q] <= 1'b0;
            end
        end
        else
        begin
            for (int q = 0; q < sram_queue_pkg::NUM_QUEUES; q++)
            begin
                // a write and a read on the same queue cancel out
                if (write_taken && write_taken_id == q && !(read_taken && read_taken_id == q))
                    word_count[q] <= word_count[q] + 1'b1;
                else if (read_taken && read_taken_id == q && !(write_taken && write_taken_id == q))
                    word_count[q] <= word_count[q] - 1'b1;
                write_full[q] <= (word_count[q] >= FULL_LEVEL); // one cycle behind the count
            end
        end
    end

    always_comb
    begin
        for (int q = 0; q < sram_queue_pkg::NUM_QUEUES; q++)
            read_empty[q] = (word_count[q] == '0);
    end

endmodule

// File: lane_fifo.sv
/* small fall-through fifo for one memory chip lane */
`timescale 1ns/1ps

module lane_fifo
#(
    parameter int LANE_DEPTH_BITS = 2
)
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [sram_queue_pkg::LANE_WIDTH-1:0] din,
    input  logic                                  wr_en,
    input  logic                                  rd_en,
    output logic [sram_queue_pkg::LANE_WIDTH-1:0] dout,
    output logic                                  empty
);

    localparam int DEPTH = 1 << LANE_DEPTH_BITS;

    logic [sram_queue_pkg::LANE_WIDTH-1:0] mem [DEPTH];
    logic [LANE_DEPTH_BITS:0]              wr_ptr; // extra bit tells full from empty
    logic [LANE_DEPTH_BITS:0]              rd_ptr;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en && !empty)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_ptr[LANE_DEPTH_BITS-1:0]] <= din;
    end

    assign empty = (wr_ptr == rd_ptr);
    assign dout  = mem[rd_ptr[LANE_DEPTH_BITS-1:0]]; // head shows without a read

endmodule

// File: read_return.sv
/* deskew of the returned memory word: three lane fifos, joint pop
   once every lane holds data, and unpacking into payload and queue id */
`timescale 1ns/1ps

module read_return
#(
    parameter int LANE_DEPTH_BITS = 2
)
(
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic [sram_queue_pkg::MEM_WORD_WIDTH-1:0] din,
    input  logic [sram_queue_pkg::NUM_LANES-1:0]      din_valid,
    output sram_queue_pkg::payload_t                  read_data,
    output sram_queue_pkg::queue_id_t                 read_data_queue_id,
    output logic                                      read_data_valid
);

    localparam int LW = sram_queue_pkg::LANE_WIDTH;

    logic [sram_queue_pkg::MEM_WORD_WIDTH-1:0] joined_word;
    logic [sram_queue_pkg::NUM_LANES-1:0]      lane_empty;
    logic                                      pop_all;

    for (genvar i = 0; i < sram_queue_pkg::NUM_LANES; i++)
    begin : g_lane
        lane_fifo #(.LANE_DEPTH_BITS(LANE_DEPTH_BITS)) u_lane_fifo (
            .clk   (clk),
            .reset (reset),
            .din   (din[i*LW +: LW]),
            .wr_en (din_valid[i]),
            .rd_en (pop_all),
            .dout  (joined_word[i*LW +: LW]),
            .empty (lane_empty[i])
        );
    end

    assign pop_all = ~|lane_empty; // no back-pressure, pop as soon as all lanes are in

    assign read_data          = joined_word[sram_queue_pkg::PAYLOAD_WIDTH-1:0];
    assign read_data_queue_id = joined_word[sram_queue_pkg::QID_LSB +: sram_queue_pkg::QUEUE_ID_WIDTH];
    assign read_data_valid    = pop_all && joined_word[sram_queue_pkg::VALID_BIT];

endmodule

// File: sram_queue_mem.sv
/* top level of the four-queue sram packet buffer, write and read
   controllers, occupancy tracker and read return path */
`timescale 1ns/1ps

module sram_queue_mem
#(
    parameter int ADDR_WIDTH      = 19,
    parameter int LANE_DEPTH_BITS = 2
)
(
    input  logic                                      clk,
    input  logic                                      reset,
    // write side
    input  logic                                      write_data_valid,
    input  sram_queue_pkg::queue_id_t                 write_queue_id,
    input  sram_queue_pkg::payload_t                  write_data,
    output logic                                      write_taken,
    output sram_queue_pkg::queue_mask_t               write_full,
    // read side
    input  logic                                      read_data_ready,
    input  sram_queue_pkg::queue_id_t                 read_queue_id,
    output logic                                      read_taken,
    output sram_queue_pkg::queue_mask_t               read_empty,
    output sram_queue_pkg::payload_t                  read_data,
    output sram_queue_pkg::queue_id_t                 read_data_queue_id,
    output logic                                      read_data_valid,
    // sram write
    output logic [sram_queue_pkg::MEM_WORD_WIDTH-1:0] dout,
    output logic [ADDR_WIDTH-1:0]                     dout_addr,
    output logic                                      dout_burst_ready,
    // sram read
    output logic [ADDR_WIDTH-1:0]                     din_addr,
    output logic                                      din_ready,
    input  logic [sram_queue_pkg::MEM_WORD_WIDTH-1:0] din,
    input  logic [sram_queue_pkg::NUM_LANES-1:0]      din_valid
);

    sram_queue_pkg::queue_id_t write_taken_id;
    sram_queue_pkg::queue_id_t read_taken_id;

    queue_write_ctrl #(.ADDR_WIDTH(ADDR_WIDTH)) u_write_ctrl (
        .clk (clk), .reset (reset),
        .write_data_valid (write_data_valid), .write_queue_id (write_queue_id),
        .write_data (write_data), .write_full (write_full),
        .write_taken (write_taken), .write_taken_id (write_taken_id),
        .dout (dout), .dout_addr (dout_addr), .dout_burst_ready (dout_burst_ready)
    );

    queue_read_ctrl #(.ADDR_WIDTH(ADDR_WIDTH)) u_read_ctrl (
        .clk (clk), .reset (reset),
        .read_data_ready (read_data_ready), .read_queue_id (read_queue_id),
        .read_empty (read_empty),
        .read_taken (read_taken), .read_taken_id (read_taken_id),
        .din_addr (din_addr), .din_ready (din_ready)
    );

    queue_occupancy #(.ADDR_WIDTH(ADDR_WIDTH)) u_occupancy (
        .clk (clk), .reset (reset),
        .write_taken (write_taken), .write_taken_id (write_taken_id),
        .read_taken (read_taken), .read_taken_id (read_taken_id),
        .read_empty (read_empty), .write_full (write_full)
    );

    read_return #(.LANE_DEPTH_BITS(LANE_DEPTH_BITS)) u_read_return (
        .clk (clk), .reset (reset),
        .din (din), .din_valid (din_valid),
        .read_data (read_data), .read_data_queue_id (read_data_queue_id),
        .read_data_valid (read_data_valid)
    );

endmodule

// File: tb_clock.sv
/* testbench clock, 4 ns period, and reset held high for 3 cycles */
`timescale 1ns/1ps

module tb_clock
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial
    begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0; // released after the third edge
    end

endmodule

// File: sram_queue_mem_assert.sv
/* concurrent checks on the top level, strobe alternation and
   no take on an empty or full queue */
`timescale 1ns/1ps

module sram_queue_mem_assert
(
    input logic                        clk,
    input logic                        reset,
    input logic                        dout_burst_ready,
    input logic                        din_ready,
    input logic                        write_taken,
    input sram_queue_pkg::queue_id_t   write_queue_id,
    input sram_queue_pkg::queue_mask_t write_full,
    input logic                        read_taken,
    input sram_queue_pkg::queue_id_t   read_queue_id,
    input sram_queue_pkg::queue_mask_t read_empty
);

    int fail_count = 0; // failed assertions so far

    a_write_strobe: assert property (@(posedge clk) disable iff (reset)
        dout_burst_ready |=> !dout_burst_ready)
        else
        begin
            fail_count++;
            $error("dout_burst_ready high in two consecutive cycles");
        end

    a_read_strobe: assert property (@(posedge clk) disable iff (reset)
        din_ready |=> !din_ready)
        else
        begin
            fail_count++;
            $error("din_ready high in two consecutive cycles");
        end

    // takes must respect the flags of the addressed queue
    a_read_not_empty: assert property (@(posedge clk) disable iff (reset)
        read_taken |-> !read_empty[read_queue_id])
        else
        begin
            fail_count++;
            $error("read taken on an empty queue");
        end

    a_write_not_full: assert property (@(posedge clk) disable iff (reset)
        write_taken |-> !write_full[write_queue_id])
        else
        begin
            fail_count++;
            $error("write taken on a full queue");
        end

endmodule

// File: sram_queue_mem_tb.sv
/* testbench top with sram lane model, biased random stimulus,
   reference queue model and compare tasks */
`timescale 1ns/1ps

module sram_queue_mem_tb;

    localparam int ADDR_WIDTH     = 8;
    localparam int OFF_W          = ADDR_WIDTH - sram_queue_pkg::QUEUE_ID_WIDTH;
    localparam int REGION         = 1 << OFF_W;
    localparam int FULL_COUNT     = REGION - sram_queue_pkg::FULL_MARGIN;
    localparam int MW             = sram_queue_pkg::MEM_WORD_WIDTH;
    localparam int LW             = sram_queue_pkg::LANE_WIDTH;
    localparam int PW             = sram_queue_pkg::PAYLOAD_WIDTH;
    localparam int RETURN_TIMEOUT = 20;
    localparam int NUM_CYCLES     = 3200;

    logic                                 clk;
    logic                                 reset;
    logic                                 write_data_valid;
    sram_queue_pkg::queue_id_t            write_queue_id;
    sram_queue_pkg::payload_t             write_data;
    logic                                 write_taken;
    sram_queue_pkg::queue_mask_t          write_full;
    logic                                 read_data_ready;
    sram_queue_pkg::queue_id_t            read_queue_id;
    logic                                 read_taken;
    sram_queue_pkg::queue_mask_t          read_empty;
    sram_queue_pkg::payload_t             read_data;
    sram_queue_pkg::queue_id_t            read_data_queue_id;
    logic                                 read_data_valid;
    logic [MW-1:0]                        dout;
    logic [ADDR_WIDTH-1:0]                dout_addr;
    logic                                 dout_burst_ready;
    logic [ADDR_WIDTH-1:0]                din_addr;
    logic                                 din_ready;
    logic [MW-1:0]                        din;
    logic [sram_queue_pkg::NUM_LANES-1:0] din_valid;

    //////////////////////////////
    // memory and reference model
    //////////////////////////////
    logic [MW-1:0]               sram [1 << ADDR_WIDTH];
    logic                        req_valid [8] = '{default: 1'b0}; // lane delay history
    logic [MW-1:0]               req_word [8];
    sram_queue_pkg::payload_t    ref_data [sram_queue_pkg::NUM_QUEUES][REGION];
    logic [OFF_W-1:0]            wr_off [sram_queue_pkg::NUM_QUEUES] = '{default: '0};
    logic [OFF_W-1:0]            rd_off [sram_queue_pkg::NUM_QUEUES] = '{default: '0};
    int                          cnt [sram_queue_pkg::NUM_QUEUES] = '{default: 0};
    sram_queue_pkg::queue_mask_t exp_full = '0;
    logic                        wr_half = 1'b0;
    logic                        rd_half = 1'b0;
    logic                        exp_wpulse = 1'b0;
    logic                        exp_rpulse = 1'b0;
    logic [ADDR_WIDTH-1:0]       exp_waddr;
    logic [ADDR_WIDTH-1:0]       exp_raddr;
    sram_queue_pkg::payload_t    exp_wdata;
    sram_queue_pkg::payload_t    pend_data [$]; // reads in flight in request order
    sram_queue_pkg::queue_id_t   pend_qid [$];
    int                          pend_cycle [$];
    int                          cycle = 0;
    int                          value_errors = 0;
    int                          other_errors = 0;
    int                          full_blocks = 0;
    int                          empty_blocks = 0;

    tb_clock u_clock (.clk(clk), .reset(reset));

    sram_queue_mem #(.ADDR_WIDTH(ADDR_WIDTH)) UUT (.*);

    bind sram_queue_mem sram_queue_mem_assert u_assert (
        .clk(clk), .reset(reset), .dout_burst_ready(dout_burst_ready), .din_ready(din_ready),
        .write_taken(write_taken), .write_queue_id(write_queue_id), .write_full(write_full),
        .read_taken(read_taken), .read_queue_id(read_queue_id), .read_empty(read_empty)
    );

    task automatic report_value(input string name, input logic [MW-1:0] got,
                                input logic [MW-1:0] exp);
        $display("ERROR %s got %0h expected %0h", name, got, exp);
        value_errors++;
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_value(name, got, exp);
    endtask

    task automatic check_payload(input string name, input sram_queue_pkg::payload_t got,
                                 input sram_queue_pkg::payload_t exp);
        if (got !== exp)
            report_value(name, got, exp);
    endtask

    task automatic check_qid(input string name, input sram_queue_pkg::queue_id_t got,
                             input sram_queue_pkg::queue_id_t exp);
        if (got !== exp)
            report_value(name, got, exp);
    endtask

    task automatic check_mask(input string name, input sram_queue_pkg::queue_mask_t got,
                              input sram_queue_pkg::queue_mask_t exp);
        if (got !== exp)
            report_value(name, got, exp);
    endtask

    task automatic check_addr(input string name, input logic [ADDR_WIDTH-1:0] got,
                              input logic [ADDR_WIDTH-1:0] exp);
        if (got !== exp)
            report_value(name, got, exp);
    endtask

    function automatic sram_queue_pkg::payload_t random_payload();
        sram_queue_pkg::payload_t p;
        p = '0;
        for (int i = 0; i < 9; i++)
            p = (p << 32) | sram_queue_pkg::payload_t'($urandom);
        return p;
    endfunction

    // one clock cycle of driving on the falling edge, checking and stepping the model
    task automatic run_cycle(input logic wv, input sram_queue_pkg::queue_id_t wq,
                             input logic rv, input sram_queue_pkg::queue_id_t rq);
        logic                        exp_wtake;
        logic                        exp_rtake;
        sram_queue_pkg::queue_mask_t exp_empty;
        @(negedge clk);
        write_data_valid = wv;
        write_queue_id   = wq;
        write_data       = random_payload();
        read_data_ready  = rv;
        read_queue_id    = rq;
        for (int i = 0; i < sram_queue_pkg::NUM_LANES; i++)
        begin
            din_valid[i]    = req_valid[(cycle - i - 1) & 7]; // lane i lags i+1 cycles
            din[i*LW +: LW] = req_word[(cycle - i - 1) & 7][i*LW +: LW];
        end
        #1;
        for (int q = 0; q < sram_queue_pkg::NUM_QUEUES; q++)
            exp_empty[q] = (cnt[q] == 0);
        exp_wtake = wv && !wr_half && !exp_full[wq];
        exp_rtake = rv && !rd_half && cnt[rq] != 0;
        check_mask("read_empty", read_empty, exp_empty);
        check_mask("write_full", write_full, exp_full);
        check_bit("write_taken", write_taken, exp_wtake);
        check_bit("read_taken", read_taken, exp_rtake);
        check_bit("dout_burst_ready", dout_burst_ready, exp_wpulse);
        if (exp_wpulse)
        begin
            check_addr("dout_addr", dout_addr, exp_waddr);
            check_payload("dout payload", dout[PW-1:0], exp_wdata);
            check_qid("dout queue id", dout[sram_queue_pkg::QID_LSB +: 2],
                      exp_waddr[ADDR_WIDTH-1 -: 2]);
            check_bit("dout word valid", dout[sram_queue_pkg::VALID_BIT], 1'b1);
            if (dout[MW-1:sram_queue_pkg::VALID_BIT+1] !== '0)
                report_value("dout padding", dout[MW-1:sram_queue_pkg::VALID_BIT+1], '0);
        end
        if (dout_burst_ready)
            sram[dout_addr] = dout;
        check_bit("din_ready", din_ready, exp_rpulse);
        if (exp_rpulse)
            check_addr("din_addr", din_addr, exp_raddr);
        req_valid[cycle & 7] = din_ready;
        req_word[cycle & 7]  = din_ready ? sram[din_addr] : '0;

        if (read_data_valid)
        begin
            if (pend_qid.size() == 0)
            begin
                $display("read data returned while no read was outstanding");
                other_errors++;
            end
            else
            begin
                check_payload("read_data", read_data, pend_data.pop_front());
                check_qid("read_data_queue_id", read_data_queue_id, pend_qid.pop_front());
                void'(pend_cycle.pop_front());
            end
        end
        if (pend_cycle.size() > 0 && cycle - pend_cycle[0] > RETURN_TIMEOUT)
        begin
            $display("read of queue %0d returned no data within %0d cycles",
                     pend_qid[0], RETURN_TIMEOUT);
            other_errors++;
            void'(pend_data.pop_front());
            void'(pend_qid.pop_front());
            void'(pend_cycle.pop_front());
        end
        if (wv && !wr_half && exp_full[wq])
            full_blocks++;
        if (rv && !rd_half && cnt[rq] == 0)
            empty_blocks++;

        // model state after the coming rising edge
        for (int q = 0; q < sram_queue_pkg::NUM_QUEUES; q++)
            exp_full[q] = (cnt[q] >= FULL_COUNT);
        exp_wpulse = exp_wtake;
        exp_rpulse = exp_rtake;
        if (exp_wtake)
        begin
            exp_waddr            = {wq, wr_off[wq]};
            exp_wdata            = write_data;
            ref_data[wq][wr_off[wq]] = write_data;
            wr_off[wq]           = wr_off[wq] + 1'b1;
            cnt[wq]++;
        end
        if (exp_rtake)
        begin
            exp_raddr = {rq, rd_off[rq]};
            pend_data.push_back(ref_data[rq][rd_off[rq]]);
            pend_qid.push_back(rq);
            pend_cycle.push_back(cycle);
            rd_off[rq] = rd_off[rq] + 1'b1;
            cnt[rq]--;
        end
        wr_half = exp_wtake;
        rd_half = exp_rtake;
        cycle++;
    endtask

    initial
    begin
        int waited;
        int assert_errors;
        void'($urandom(32'h9d74_3319));
        write_data_valid = 1'b0;
        write_queue_id   = '0;
        write_data       = '0;
        read_data_ready  = 1'b0;
        read_queue_id    = '0;
        din              = '0;
        din_valid        = '0;

        waited = 0;
        while (reset !== 1'b0 && waited < 20)
        begin
            @(negedge clk);
            waited++;
        end
        if (reset !== 1'b0)
        begin
            $display("reset was never released");
            other_errors++;
        end

        repeat (3) run_cycle(1'b0, '0, 1'b0, '0); // idle state right after reset

        // even phases fill one focus queue and odd phases drain it
        for (int c = 0; c < NUM_CYCLES; c++)
        begin
            logic                      fill;
            sram_queue_pkg::queue_id_t focus;
            sram_queue_pkg::queue_id_t wq;
            sram_queue_pkg::queue_id_t rq;
            fill  = ((c / 400) % 2) == 0;
            focus = sram_queue_pkg::queue_id_t'(c / 800);
            wq    = ($urandom % 4 < 3) ? focus : sram_queue_pkg::queue_id_t'($urandom);
            rq    = (!fill && $urandom % 2 == 0) ? focus : sram_queue_pkg::queue_id_t'($urandom);
            run_cycle(($urandom % 100) < (fill ? 90 : 30), wq,
                      ($urandom % 100) < (fill ? 25 : 90), rq);
        end

        waited = 0;
        while (pend_qid.size() > 0 && waited < 4 * RETURN_TIMEOUT)
        begin
            run_cycle(1'b0, '0, 1'b0, '0);
            waited++;
        end
        if (pend_qid.size() > 0)
        begin
            $display("reads still outstanding when the drain timed out");
            other_errors++;
        end
        if (full_blocks == 0 || empty_blocks == 0)
        begin
            $display("stimulus never met a full queue or never met an empty queue");
            other_errors++;
        end

        assert_errors = UUT.u_assert.fail_count;
        $display("errors: %0d value, %0d other, %0d assertion",
                 value_errors, other_errors, assert_errors);
        if (value_errors + other_errors + assert_errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: sram_queue_mem.f
sram_queue_pkg.sv
queue_write_ctrl.sv
queue_read_ctrl.sv
queue_occupancy.sv
lane_fifo.sv
read_return.sv
sram_queue_mem.sv
tb_clock.sv
sram_queue_mem_assert.sv
sram_queue_mem_tb.sv

// File: Makefile
TOP := sram_queue_mem_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sram_queue_mem.f *.sv
	verilator --binary --timing --assert -Wno-fatal -f sram_queue_mem.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

lint:
	verilator --lint-only --timing -Wall -f sram_queue_mem.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
